//--- design/alu_pipe_consts.svh
// width and opcode-count macros for the ALU pipeline, included by the package and the testbench
`ifndef ALU_PIPE_CONSTS_SVH
`define ALU_PIPE_CONSTS_SVH

// ------------------------------
// datapath widths
// ------------------------------

// operand and result width, all ops wrap at this size
`define ALU_DATA_W 32

// request tag, echoed back unchanged with the result
`define ALU_TAG_W 4

// ------------------------------
// opcode space
// ------------------------------

// add, sub, and, xor
`define ALU_NUM_OPS 4

`endif

//--- design/alu_pipe_pkg.sv
// shared types of the ALU pipeline: opcode enum plus request and response structs
`include "alu_pipe_consts.svh"

package alu_pipe_pkg;

  // ------------------------------
  // opcodes
  // ------------------------------

  // encoding width follows the opcode count
  typedef enum logic [$clog2(`ALU_NUM_OPS)-1:0] {
    OP_ADD,  // opa + opb
    OP_SUB,  // opa - opb, wrapping
    OP_AND,  // bitwise and
    OP_XOR   // bitwise xor
  } alu_op_e;

  // ------------------------------
  // stream payloads
  // ------------------------------

  // request word, 70 bits, op in the msbs
  typedef struct packed {
    alu_op_e               op;   // operation to perform
    logic [`ALU_TAG_W-1:0] tag;  // returned with the result
    logic [`ALU_DATA_W-1:0] opa; // first operand
    logic [`ALU_DATA_W-1:0] opb; // second operand
  } alu_req_t;

  // response word, 36 bits
  typedef struct packed {
    logic [`ALU_TAG_W-1:0]  tag;  // copy of the request tag
    logic [`ALU_DATA_W-1:0] res;  // operation result
  } alu_rsp_t;

endpackage

//--- design/spill_cell_flush_cu.sv
// control FSM of a flushable spill cell, drives register enables, mux select and handshake
`timescale 1ns/1ps

module spill_cell_flush_cu (
  // clock, reset, flush
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,   // sync, empties both registers

  // handshake
  input  logic valid_i,   // upstream has data
  input  logic ready_i,   // downstream can take data
  output logic valid_o,   // cell holds data for downstream
  output logic ready_o,   // cell can take data from upstream

  // datapath control
  output logic a_en_o,    // load register A
  output logic b_en_o,    // load register B
  output logic b_sel_o    // output mux, 1 picks B
);

  // ------------------------------
  // state encoding
  // ------------------------------

  typedef enum logic [2:0] {
    S_RESET,     // one cycle after reset release, nothing accepted
    S_EMPTY,     // A and B both free
    S_A_FULL,    // only A holds data
    S_B_FULL,    // only B holds data
    S_AB_SEL_A,  // both full, A is older
    S_AB_SEL_B   // both full, B is older
  } cu_state_e;

  cu_state_e curr_state;
  cu_state_e next_state;

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin : next_state_eval
    next_state = curr_state;
    case (curr_state)
      S_RESET: begin
        next_state = S_EMPTY;  // always leave after one cycle
      end

      // new data lands in A
      S_EMPTY: begin
        if (valid_i) begin
          next_state = S_A_FULL;
        end
      end

      // new data goes to B, A drains if downstream takes it
      S_A_FULL: begin
        if (valid_i) begin
          next_state = ready_i ? S_B_FULL : S_AB_SEL_A;
        end else if (ready_i) begin
          next_state = S_EMPTY;
        end
      end

      // mirror of A_FULL, roles swapped
      S_B_FULL: begin
        if (valid_i) begin
          next_state = ready_i ? S_A_FULL : S_AB_SEL_B;
        end else if (ready_i) begin
          next_state = S_EMPTY;
        end
      end

      // A leaves first, then B is the only item
      S_AB_SEL_A: begin
        if (ready_i) begin
          next_state = S_B_FULL;
        end
      end

      // B leaves first, then A is the only item
      S_AB_SEL_B: begin
        if (ready_i) begin
          next_state = S_A_FULL;
        end
      end

      default: begin
        next_state = S_RESET;  // illegal encoding, recover
      end
    endcase
  end

  // ------------------------------
  // outputs (mealy)
  // ------------------------------

  // enables only fire with valid_i high, keeps regs quiet when idle
  // ready_o never looks at ready_i, so no comb path back through the cell
  always_comb begin : output_eval
    valid_o = 1'b0;
    ready_o = 1'b0;
    a_en_o  = 1'b0;
    b_en_o  = 1'b0;
    b_sel_o = 1'b0;
    case (curr_state)
      S_EMPTY: begin
        ready_o = ~flush_i;  // room in both regs
        a_en_o  = valid_i;   // fill A first
      end
      S_A_FULL: begin
        valid_o = 1'b1;      // A on the output
        ready_o = ~flush_i;
        b_en_o  = valid_i;   // spill into B
      end
      S_B_FULL: begin
        valid_o = 1'b1;
        ready_o = ~flush_i;
        a_en_o  = valid_i;   // B busy, refill A
        b_sel_o = 1'b1;      // B on the output
      end
      S_AB_SEL_A: begin
        valid_o = 1'b1;      // full, upstream stalls
      end
      S_AB_SEL_B: begin
        valid_o = 1'b1;
        b_sel_o = 1'b1;
      end
      default: begin
        // reset state keeps everything low
      end
    endcase
  end

  // ------------------------------
  // state register
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      curr_state <= S_RESET;
    end else if (flush_i) begin
      curr_state <= S_EMPTY;  // drop whatever is held
    end else begin
      curr_state <= next_state;
    end
  end

endmodule

//--- design/spill_cell_flush.sv
// flushable spill cell, two payload registers and an output mux around the control FSM
`timescale 1ns/1ps

module spill_cell_flush #(
  parameter type DATA_T = alu_pipe_pkg::alu_req_t  // payload carried by the cell
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,   // drops both held items

  // upstream side
  input  logic  valid_i,
  input  DATA_T data_i,
  output logic  ready_o,   // registered, no path from ready_i

  // downstream side
  output logic  valid_o,
  output DATA_T data_o,
  input  logic  ready_i
);

  logic  a_en;     // load A
  logic  b_en;     // load B
  logic  b_sel;    // 1 drives B on the output
  DATA_T reg_a_q;  // main register
  DATA_T reg_b_q;  // spill register

  // ------------------------------
  // control
  // ------------------------------

  spill_cell_flush_cu u_cu (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .ready_i (ready_i),
    .valid_o (valid_o),
    .ready_o (ready_o),
    .a_en_o  (a_en),
    .b_en_o  (b_en),
    .b_sel_o (b_sel)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  // FSM never raises both enables at once
  always_ff @(posedge clk_i or negedge rst_ni) begin : payload_regs
    if (!rst_ni) begin
      reg_a_q <= '0;
      reg_b_q <= '0;
    end else begin
      if (a_en) reg_a_q <= data_i;
      if (b_en) reg_b_q <= data_i;
    end
  end

  assign data_o = b_sel ? reg_b_q : reg_a_q;  // older item goes out first

endmodule

//--- design/alu_stage.sv
// combinational ALU between the two spill cells, turns a request into a response
`timescale 1ns/1ps

module alu_stage (
  // from input cell
  input  logic                   valid_i,
  input  alu_pipe_pkg::alu_req_t req_i,
  output logic                   ready_o,   // back to input cell

  // to output cell
  output logic                   valid_o,
  output alu_pipe_pkg::alu_rsp_t rsp_o,
  input  logic                   ready_i    // from output cell
);

  import alu_pipe_pkg::*;

  // ------------------------------
  // operation decode
  // ------------------------------

  // all ops wrap at the data width, no flags
  always_comb begin : alu_eval
    rsp_o.tag = req_i.tag;  // tag rides along untouched
    case (req_i.op)
      OP_ADD: begin
        rsp_o.res = req_i.opa + req_i.opb;
      end
      OP_SUB: begin
        rsp_o.res = req_i.opa - req_i.opb;  // opa minus opb
      end
      OP_AND: begin
        rsp_o.res = req_i.opa & req_i.opb;
      end
      OP_XOR: begin
        rsp_o.res = req_i.opa ^ req_i.opb;
      end
      default: begin
        rsp_o.res = '0;  // unreachable, enum is full
      end
    endcase
  end

  // ------------------------------
  // handshake
  // ------------------------------

  // zero latency stage, flags pass straight through
  assign valid_o = valid_i;
  assign ready_o = ready_i;  // out cell ready is registered, no long comb path

endmodule

//--- design/alu_pipe_top.sv
// top of the elastic ALU pipeline: input spill cell, ALU, output spill cell
`timescale 1ns/1ps

module alu_pipe_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,      // empties both cells

  // request stream
  input  logic                   req_valid_i,
  input  alu_pipe_pkg::alu_req_t req_i,
  output logic                   req_ready_o,

  // response stream
  output logic                   rsp_valid_o,
  output alu_pipe_pkg::alu_rsp_t rsp_o,
  input  logic                   rsp_ready_i
);

  import alu_pipe_pkg::*;

  logic     in_valid;   // input cell holds a request
  alu_req_t in_req;     // request at input cell output
  logic     in_ready;   // out cell ready, routed through the ALU
  logic     alu_valid;  // response valid into output cell
  alu_rsp_t alu_rsp;    // computed response
  logic     out_ready;  // output cell can take a response

  // ------------------------------
  // stage 1, request buffer
  // ------------------------------

  spill_cell_flush #(
    .DATA_T (alu_req_t)
  ) u_in_cell (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (req_valid_i),
    .data_i  (req_i),
    .ready_o (req_ready_o),
    .valid_o (in_valid),
    .data_o  (in_req),
    .ready_i (in_ready)
  );

  // ------------------------------
  // comb ALU, no latency
  // ------------------------------

  alu_stage u_alu (
    .valid_i (in_valid),
    .req_i   (in_req),
    .ready_o (in_ready),
    .valid_o (alu_valid),
    .rsp_o   (alu_rsp),
    .ready_i (out_ready)
  );

  // ------------------------------
  // stage 2, response buffer
  // ------------------------------

  spill_cell_flush #(
    .DATA_T (alu_rsp_t)
  ) u_out_cell (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (alu_valid),
    .data_i  (alu_rsp),
    .ready_o (out_ready),
    .valid_o (rsp_valid_o),
    .data_o  (rsp_o),
    .ready_i (rsp_ready_i)
  );

endmodule

//--- testbench/alu_pipe_props.sv
// handshake and flush assertions for the ALU pipeline, bound into the top level by the testbench
`timescale 1ns/1ps

module alu_pipe_props (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   flush_i,
  input logic                   req_ready_o,   // observed top level outputs
  input logic                   rsp_valid_o,
  input alu_pipe_pkg::alu_rsp_t rsp_o,
  input logic                   rsp_ready_i
);

  int fail_cnt = 0;  // read by the testbench at the end

  // ------------------------------
  // response stream
  // ------------------------------

  // stalled response stays put, only a flush may drop it
  property rsp_held_p;
    @(posedge clk_i) disable iff (!rst_ni)
      (rsp_valid_o && !rsp_ready_i && !flush_i) |=> (rsp_valid_o && $stable(rsp_o));
  endproperty

  // ------------------------------
  // flush
  // ------------------------------

  property flush_blocks_req_p;
    @(posedge clk_i) disable iff (!rst_ni)
      flush_i |-> !req_ready_o;
  endproperty

  // both cells empty once the flush edge has passed
  property flush_empties_p;
    @(posedge clk_i) disable iff (!rst_ni)
      flush_i |=> !rsp_valid_o;
  endproperty

  rsp_held_a: assert property (rsp_held_p) else begin
    $error("rsp_o changed or dropped while rsp_ready_i was low");
    fail_cnt++;
  end

  flush_blocks_req_a: assert property (flush_blocks_req_p) else begin
    $error("req_ready_o high during flush");
    fail_cnt++;
  end

  flush_empties_a: assert property (flush_empties_p) else begin
    $error("rsp_valid_o high in the cycle after a flush");
    fail_cnt++;
  end

endmodule

//--- testbench/tb_alu_pipe.sv
// simulation top that drives the ALU pipeline from a table and scoreboards its responses
`timescale 1ns/1ps
`include "alu_pipe_consts.svh"

module tb_alu_pipe;

  import alu_pipe_pkg::*;

  localparam int NUM_TESTS   = 10;
  localparam int BURST       = 6;                            // requests per table entry
  localparam int TIMEOUT_CYC = NUM_TESTS * BURST * 8 + 100;  // 8 cycles per request plus slack

  typedef struct packed {
    alu_op_e                op;
    logic [`ALU_DATA_W-1:0] opa;    // used by the first request only
    logic [`ALU_DATA_W-1:0] opb;
    logic [`ALU_DATA_W-1:0] res;    // expected result of the first request
    logic [7:0]             stall;  // rsp_ready_i per cycle or 0 for a random one
    logic                   flush;  // flush halfway through the burst
  } test_entry_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  req_valid_i;
  alu_req_t              req_i;
  logic                  req_ready_o;
  logic                  rsp_valid_o;
  alu_rsp_t              rsp_o;
  logic                  rsp_ready_i;
  test_entry_t           tbl [NUM_TESTS];
  alu_rsp_t              exp_q [$];          // expected responses in arrival order
  int                    acc_q [$];          // accept edge of each outstanding request
  integer                seed      = 32'h67587b75;
  logic [7:0]            stall_pat = 8'hff;
  logic [2:0]            stall_idx = 3'd0;
  logic                  lat_check = 1'b0;   // no stalls means exact latency and full rate
  logic                  tbl_pending = 1'b0; // next accepted request expects tbl_res
  logic [`ALU_DATA_W-1:0] tbl_res  = '0;
  logic [`ALU_TAG_W-1:0] tag_cnt   = '0;
  int                    cyc_cnt   = 0;
  int                    edge_cnt  = 0;
  int                    err_cnt   = 0;
  int                    ok_cnt    = 0;
  int                    bad_cnt   = 0;

  always #2 clk_i = ~clk_i;  // 4 ns period

  alu_pipe_top u_alu_pipe_top (.*);

  bind alu_pipe_top alu_pipe_props u_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

  // ------------------------------
  // checks and model
  // ------------------------------

  task automatic check_rsp(input alu_rsp_t got, input alu_rsp_t exp);
    if (got.tag !== exp.tag) begin
      $display("ERR t=%0t rsp_o.tag got %0h exp %0h", $time, got.tag, exp.tag);
      err_cnt++;
    end
    if (got.res !== exp.res) begin
      $display("ERR t=%0t rsp_o.res got %08h exp %08h", $time, got.res, exp.res);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("ERR t=%0t rsp_valid_o latency got %0d exp %0d", $time, got, exp);
      err_cnt++;
    end
  endtask

  // sub as two's complement add and xor from or/and
  function automatic alu_rsp_t predict_rsp(input alu_req_t req);
    alu_rsp_t rsp;
    rsp     = '0;
    rsp.tag = req.tag;
    case (req.op)
      OP_ADD: rsp.res = req.opa + req.opb;
      OP_SUB: rsp.res = req.opa + ~req.opb + 1'b1;
      OP_AND: rsp.res = req.opa & req.opb;
      OP_XOR: rsp.res = (req.opa | req.opb) & ~(req.opa & req.opb);
      default: rsp.res = '0;
    endcase
    return rsp;
  endfunction

  // ------------------------------
  // stall driver, watchdog, scoreboard
  // ------------------------------

  always @(negedge clk_i) begin : ready_drive
    rsp_ready_i = stall_pat[stall_idx];
    stall_idx   = stall_idx + 3'd1;  // pattern repeats every 8 cycles
  end

  always @(posedge clk_i) begin : watchdog
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt > TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(posedge clk_i) begin : scoreboard
    alu_rsp_t exp_rsp;
    int       acc;
    edge_cnt = edge_cnt + 1;
    if (rst_ni) begin
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("t=%0t response with tag %0h arrived, none outstanding", $time, rsp_o.tag);
          err_cnt++;
        end else begin
          exp_rsp = exp_q.pop_front();
          acc     = acc_q.pop_front();
          check_rsp(rsp_o, exp_rsp);
          if (lat_check) check_latency(edge_cnt - acc, 2);
        end
      end
      if (req_valid_i && req_ready_o) begin
        exp_rsp = predict_rsp(req_i);
        if (tbl_pending) begin
          exp_rsp.res = tbl_res;  // directed request, result from the table
          tbl_pending = 1'b0;
        end
        exp_q.push_back(exp_rsp);
        acc_q.push_back(edge_cnt);
      end
      if (lat_check && req_valid_i) check_bit("req_ready_o", req_ready_o, 1'b1);
      if (flush_i) begin
        check_bit("req_ready_o", req_ready_o, 1'b0);
        exp_q.delete();  // in-flight items are gone
        acc_q.delete();
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  function automatic test_entry_t make_entry(input alu_op_e op, input logic [31:0] opa,
                                             input logic [31:0] opb, input logic [31:0] res,
                                             input logic [7:0] stall, input logic flush);
    test_entry_t e;
    e.op    = op;
    e.opa   = opa;
    e.opb   = opb;
    e.res   = res;
    e.stall = stall;
    e.flush = flush;
    return e;
  endfunction

  task automatic load_table();
    // results worked out by hand with 32-bit wrap
    tbl[0] = make_entry(OP_ADD, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001, 8'hff, 1'b0);
    tbl[1] = make_entry(OP_SUB, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 8'hff, 1'b0);
    tbl[2] = make_entry(OP_AND, 32'hf0f0_a5a5, 32'hff00_0ff0, 32'hf000_05a0, 8'hff, 1'b0);
    tbl[3] = make_entry(OP_XOR, 32'hdead_beef, 32'hffff_0000, 32'h2152_beef, 8'hff, 1'b0);
    tbl[4] = make_entry(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 8'b1010_0110, 1'b0);
    tbl[5] = make_entry(OP_SUB, 32'h1234_5678, 32'h8765_4321, 32'h8acf_1357, 8'h00, 1'b0);
    tbl[6] = make_entry(OP_XOR, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 8'h00, 1'b0);
    tbl[7] = make_entry(OP_AND, 32'hffff_ffff, 32'h1357_9bdf, 32'h1357_9bdf, 8'hff, 1'b1);
    tbl[8] = make_entry(OP_ADD, 32'h0000_0010, 32'h0000_0020, 32'h0000_0030, 8'b0001_0011, 1'b1);
    tbl[9] = make_entry(OP_SUB, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 8'h00, 1'b0);
  endtask

  // called at a falling edge and returns at the falling edge after the handshake
  task automatic send_req(input alu_op_e op, input logic [31:0] opa, input logic [31:0] opb);
    req_valid_i = 1'b1;
    req_i.op    = op;
    req_i.tag   = tag_cnt;
    req_i.opa   = opa;
    req_i.opb   = opb;
    tag_cnt     = tag_cnt + 1'b1;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic report_test(input string label, input int errs_before);
    if (err_cnt == errs_before) begin
      ok_cnt++;
      $display("%s: ok", label);
    end else begin
      bad_cnt++;
      $display("%s: %0d errors", label, err_cnt - errs_before);
    end
  endtask

  task automatic run_test(input int idx);
    test_entry_t e;
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    int          errs_before;
    e           = tbl[idx];
    errs_before = err_cnt;
    rnd         = $random(seed);
    @(posedge clk_i);
    stall_pat = (e.stall != 8'h00) ? e.stall : (rnd[7:0] | 8'h01);  // never all stalled
    @(negedge clk_i);
    lat_check = (e.stall == 8'hff) && !e.flush;
    for (int i = 0; i < BURST; i++) begin
      if (e.flush && i == BURST / 2) begin
        flush_i = 1'b1;  // earlier requests still in flight
        @(negedge clk_i);
        flush_i = 1'b0;
        check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
      end
      a = e.opa;
      b = e.opb;
      if (i != 0) begin
        a = $random(seed);
        b = $random(seed);
      end else begin
        tbl_res     = e.res;
        tbl_pending = 1'b1;
      end
      send_req(e.op, a, b);
    end
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);  // nothing stale or doubled
    lat_check = 1'b0;
    report_test($sformatf("test %0d %s stall %b flush %0b", idx, e.op.name(), stall_pat,
                          e.flush), errs_before);
  endtask

  initial begin : main
    int errs_before;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    load_table();
    repeat (10) @(negedge clk_i);
    rst_ni      = 1'b1;
    errs_before = err_cnt;
    #1;
    check_bit("req_ready_o", req_ready_o, 1'b0);  // still in reset state
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    report_test("reset release", errs_before);
    for (int i = 0; i < NUM_TESTS; i++) run_test(i);
    if (u_alu_pipe_top.u_props.fail_cnt != 0) begin
      $display("%0d assertion failures seen", u_alu_pipe_top.u_props.fail_cnt);
      err_cnt += u_alu_pipe_top.u_props.fail_cnt;
    end
    $display("summary: %0d tests, %0d ok, %0d failing, %0d errors", ok_cnt + bad_cnt, ok_cnt,
             bad_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+design
design/alu_pipe_pkg.sv
design/spill_cell_flush_cu.sv
design/spill_cell_flush.sv
design/alu_stage.sv
design/alu_pipe_top.sv
testbench/alu_pipe_props.sv
testbench/tb_alu_pipe.sv

//--- Bender.yml
package:
  name: alu_pipe

sources:
  # synthesizable pipeline
  - include_dirs:
      - design
    files:
      - design/alu_pipe_pkg.sv
      - design/spill_cell_flush_cu.sv
      - design/spill_cell_flush.sv
      - design/alu_stage.sv
      - design/alu_pipe_top.sv
  # simulation only
  - target: test
    include_dirs:
      - design
    files:
      - testbench/alu_pipe_props.sv
      - testbench/tb_alu_pipe.sv
